// ==== Bender.yml ====
package:
  name: i2c_bit_ctrl

sources:
  - i2c_bit_pkg.sv
  - i2c_clk_div.sv
  - i2c_line_filter.sv
  - i2c_bus_monitor.sv
  - i2c_bit_fsm.sv
  - i2c_bit_ctrl.sv
  - target: test
    files:
      - i2c_bit_ctrl_tb.sv

// ==== i2c_bit_ctrl.f ====
i2c_bit_pkg.sv
i2c_clk_div.sv
i2c_line_filter.sv
i2c_bus_monitor.sv
i2c_bit_fsm.sv
i2c_bit_ctrl.sv
i2c_bit_ctrl_tb.sv

// ==== i2c_bit_ctrl.sv ====
/*
 * I2C master bit controller
 * clock divider, line filter, bus monitor and bit sequencer
 */
`timescale 1ns/100ps

module i2c_bit_ctrl import i2c_bit_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  ena_i,       // core enable
  input  logic [PRESCALE_W-1:0] prescale_i,  // bus clock prescale
  input  i2c_cmd_e              cmd_i,
  input  logic                  tx_bit_i,
  input  logic                  scl_i,       // bus SCL level
  input  logic                  sda_i,       // bus SDA level
  output logic                  cmd_ack_o,
  output logic                  busy_o,
  output logic                  rx_bit_o,
  output logic                  scl_dir_o,   // 0 pulls SCL low
  output logic                  sda_dir_o    // 0 pulls SDA low
);

  logic scl_s, sda_s;  // filtered bus levels
  logic clk_en;        // bus tick

  i2c_clk_div u_clk_div (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ena_i      (ena_i),
    .prescale_i (prescale_i),
    .scl_dir_i  (scl_dir_o),  // fed back for stretch detect
    .scl_s_i    (scl_s),
    .clk_en_o   (clk_en)
  );

  i2c_line_filter u_line_filter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ena_i      (ena_i),
    .prescale_i (prescale_i),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_s_o    (scl_s),
    .sda_s_o    (sda_s)
  );

  i2c_bus_monitor u_bus_monitor (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .scl_s_i  (scl_s),
    .sda_s_i  (sda_s),
    .busy_o   (busy_o),
    .rx_bit_o (rx_bit_o)
  );

  i2c_bit_fsm u_bit_fsm (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .clk_en_i  (clk_en),
    .cmd_i     (cmd_i),
    .tx_bit_i  (tx_bit_i),
    .cmd_ack_o (cmd_ack_o),
    .scl_dir_o (scl_dir_o),
    .sda_dir_o (sda_dir_o)
  );

endmodule

// ==== i2c_bit_ctrl_tb.sv ====
/*
 * I2C bit controller testbench
 * open-drain bus with slave model, directed start/stop, write, read, stretch, glitch
 */
`timescale 1ns/100ps

module i2c_bit_ctrl_tb import i2c_bit_pkg::*; ();

  localparam int CLK_PERIOD    = 4;
  localparam int PRESCALE      = 16;
  localparam int SAMPLE_PERIOD = PRESCALE / 4 + 1;        // filter sample period
  localparam int BUSY_LIMIT    = 4 * SAMPLE_PERIOD;
  localparam int MAX_STRETCH   = 60;
  localparam int ACK_LIMIT     = 8 * (PRESCALE + 1) + 2 * MAX_STRETCH;
  localparam int NUM_CMDS      = 24;                      // commands over all tests
  localparam int RUN_CYCLES    = NUM_CMDS * ACK_LIMIT + 40 * SAMPLE_PERIOD + 200;
  localparam logic [31:0] SEED = 32'hc610;

  logic clk_i = 1'b0;
  logic rst_n_i, ena_i, tx_bit_i;
  logic [PRESCALE_W-1:0] prescale_i;
  i2c_cmd_e cmd_i;
  logic cmd_ack_o, busy_o, rx_bit_o, scl_dir_o, sda_dir_o;
  logic slv_scl, slv_sda;  // slave side of the open-drain lines, 0 pulls low
  wire  scl_i = scl_dir_o & slv_scl;
  wire  sda_i = sda_dir_o & slv_sda;

  int   errors = 0, tests_run = 0, tests_failed = 0;
  int   bit_cnt = 0, start_cnt = 0, stop_cnt = 0;  // bus observer counts
  logic [7:0] mon_bits = '0;                     // sampled SDA, newest in bit 0
  logic scl_prev = 1'b1, sda_prev = 1'b1;
  time  last_ack_t;

  i2c_bit_ctrl UUT (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .ena_i (ena_i), .prescale_i (prescale_i),
    .cmd_i (cmd_i), .tx_bit_i (tx_bit_i), .scl_i (scl_i), .sda_i (sda_i),
    .cmd_ack_o (cmd_ack_o), .busy_o (busy_o), .rx_bit_o (rx_bit_o),
    .scl_dir_o (scl_dir_o), .sda_dir_o (sda_dir_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // bus observer on the rising edge, away from the falling-edge drive
  // SDA taken at each SCL rise, start/stop with SCL high
  always @(posedge clk_i) begin
    if (scl_i && !scl_prev) begin
      mon_bits <= {mon_bits[6:0], sda_i};
      bit_cnt  <= bit_cnt + 1;
    end
    if (scl_i && scl_prev && sda_prev && !sda_i) start_cnt <= start_cnt + 1;
    if (scl_i && scl_prev && !sda_prev && sda_i) stop_cnt <= stop_cnt + 1;
    scl_prev <= scl_i;
    sda_prev <= sda_i;
  end

  // hard stop in case anything hangs
  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    errors++;
  endtask

  task automatic plain_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic close_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, errors - err_start);
      tests_failed++;
    end
  endtask

  // hold command until ack, then back to nop in the ack cycle
  task automatic do_cmd(input i2c_cmd_e cmd, input logic bit_v);
    int n;
    @(negedge clk_i);
    cmd_i    = cmd;
    tx_bit_i = bit_v;  // stable for the whole command
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!cmd_ack_o && n < ACK_LIMIT);
    cmd_i      = CMD_NOP;
    last_ack_t = $time;
    if (!cmd_ack_o) plain_error($sformatf("no acknowledge for %s", cmd.name()));
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (busy_o !== level && n < BUSY_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic reset_values();
    int e0;
    e0 = errors;
    if (cmd_ack_o !== 1'b0) value_error("cmd_ack_o", cmd_ack_o, 0);
    if (busy_o !== 1'b0)    value_error("busy_o", busy_o, 0);
    if (rx_bit_o !== 1'b0)  value_error("rx_bit_o", rx_bit_o, 0);
    if (scl_dir_o !== 1'b1) value_error("scl_dir_o", scl_dir_o, 1);
    if (sda_dir_o !== 1'b1) value_error("sda_dir_o", sda_dir_o, 1);
    close_test("reset", e0);
  endtask

  task automatic start_stop_seq();
    int e0, s0, p0;
    e0 = errors;
    s0 = start_cnt;
    do_cmd(CMD_START, 1'b0);
    if (start_cnt != s0 + 1) plain_error("no SDA fall with SCL high during start");
    wait_busy(1'b1);
    if (busy_o !== 1'b1) value_error("busy_o", busy_o, 1);
    p0 = stop_cnt;
    do_cmd(CMD_STOP, 1'b0);
    @(negedge clk_i);  // observer catches the SDA rise
    wait_busy(1'b0);
    if (busy_o !== 1'b0) value_error("busy_o", busy_o, 0);
    if (stop_cnt != p0 + 1) plain_error("no SDA rise with SCL high during stop");
    close_test("start_stop", e0);
  endtask

  task automatic write_byte();
    int e0, b0;
    logic [7:0] data;
    e0   = errors;
    data = 8'($urandom);
    do_cmd(CMD_START, 1'b0);
    b0 = bit_cnt;
    for (int i = 7; i >= 0; i--) do_cmd(CMD_WRITE, data[i]);  // MSB first
    @(negedge clk_i);
    if (bit_cnt != b0 + 8) value_error("scl rises", bit_cnt - b0, 8);
    if (mon_bits !== data) value_error("sda bits", mon_bits, data);
    close_test("write_byte", e0);
  endtask

  task automatic read_byte();
    int e0;
    logic [7:0] data;
    e0   = errors;
    data = 8'($urandom);
    for (int i = 7; i >= 0; i--) begin
      @(negedge clk_i);
      slv_sda = data[i];  // SCL is low between commands
      do_cmd(CMD_READ, 1'b0);
      if (rx_bit_o !== data[i]) value_error("rx_bit_o", rx_bit_o, data[i]);
    end
    @(negedge clk_i);
    slv_sda = 1'b1;
    close_test("read_byte", e0);
  endtask

  task automatic stretch_write();
    int   e0, hold, b0;
    logic b;
    time  rel_t;
    e0    = errors;
    hold  = $urandom_range(MAX_STRETCH, 20);
    b     = 1'($urandom);
    b0    = bit_cnt;
    rel_t = 0;
    @(negedge clk_i);
    slv_scl = 1'b0;  // slave grabs SCL before the master lets go
    fork
      do_cmd(CMD_WRITE, b);
      begin
        while (scl_dir_o !== 1'b1) @(negedge clk_i);
        repeat (hold) @(negedge clk_i);
        slv_scl = 1'b1;
        rel_t   = $time;
      end
    join
    @(negedge clk_i);
    // the last phase needs a full bus period after the count resumes
    if (last_ack_t < rel_t + (PRESCALE + 1) * CLK_PERIOD)
      plain_error("acknowledge came less than one bus period after the SCL release");
    if (bit_cnt != b0 + 1) value_error("scl rises", bit_cnt - b0, 1);
    if (mon_bits[0] !== b) value_error("sda bit", mon_bits[0], b);
    close_test("stretch", e0);
  endtask

  task automatic glitch_reject();
    int   e0;
    logic hit;
    e0  = errors;
    hit = 1'b0;
    do_cmd(CMD_STOP, 1'b0);
    wait_busy(1'b0);
    if (busy_o !== 1'b0) value_error("busy_o", busy_o, 0);
    // one-cycle low pulses, each one cycle later against the sample timer
    for (int k = 0; k < SAMPLE_PERIOD; k++) begin
      repeat (4 * SAMPLE_PERIOD) begin  // filter history settles high
        @(negedge clk_i);
        if (busy_o !== 1'b0) hit = 1'b1;
      end
      slv_sda = 1'b0;
      @(negedge clk_i);
      slv_sda = 1'b1;
    end
    repeat (8 * SAMPLE_PERIOD) begin
      @(negedge clk_i);
      if (busy_o !== 1'b0) hit = 1'b1;
    end
    if (hit) value_error("busy_o", 1, 0);
    close_test("glitch", e0);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n_i    = 1'b0;
    ena_i      = 1'b1;
    prescale_i = PRESCALE_W'(PRESCALE);
    cmd_i      = CMD_NOP;
    tx_bit_i   = 1'b0;
    slv_scl    = 1'b1;
    slv_sda    = 1'b1;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    reset_values();
    start_stop_seq();
    write_byte();
    read_byte();
    stretch_write();
    glitch_reject();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== i2c_bit_fsm.sv ====
/*
 * I2C bit command sequencer
 * steps start, stop, write and read through their SCL/SDA phases on each tick
 */
`timescale 1ns/100ps

module i2c_bit_fsm import i2c_bit_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     clk_en_i,   // bus tick
  input  i2c_cmd_e cmd_i,      // held until ack
  input  logic     tx_bit_i,   // bit for write
  output logic     cmd_ack_o,  // one-cycle done pulse
  output logic     scl_dir_o,  // 1 releases SCL
  output logic     sda_dir_o   // 1 releases SDA
);

  bit_state_e state;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state     <= ST_IDLE;
      cmd_ack_o <= 1'b0;
      scl_dir_o <= 1'b1;
      sda_dir_o <= 1'b1;
    end else begin
      cmd_ack_o <= 1'b0;  // pulse only
      if (clk_en_i) begin
        unique case (state)
          ST_IDLE: begin
            unique case (cmd_i)
              CMD_START: state <= ST_START_A;
              CMD_STOP:  state <= ST_STOP_A;
              CMD_WRITE: state <= ST_WR_A;
              CMD_READ:  state <= ST_RD_A;
              default:   state <= ST_IDLE;
            endcase
          end

          ////////////////////////////////////////////////////////////
          // start / repeated start
          ////////////////////////////////////////////////////////////
          ST_START_A: begin
            state     <= ST_START_B;
            sda_dir_o <= 1'b1;  // SDA up, SCL as it was
          end
          ST_START_B: begin
            state     <= ST_START_C;
            scl_dir_o <= 1'b1;  // SCL up
          end
          ST_START_C: begin
            state     <= ST_START_D;
            sda_dir_o <= 1'b0;  // SDA falls with SCL high
          end
          ST_START_D: begin
            state <= ST_START_E;  // hold time
          end
          ST_START_E: begin
            state     <= ST_IDLE;
            scl_dir_o <= 1'b0;
            cmd_ack_o <= 1'b1;
          end

          ////////////////////////////////////////////////////////////
          // stop
          ////////////////////////////////////////////////////////////
          ST_STOP_A: begin
            state     <= ST_STOP_B;
            scl_dir_o <= 1'b0;
            sda_dir_o <= 1'b0;  // SDA low before SCL goes up
          end
          ST_STOP_B: begin
            state     <= ST_STOP_C;
            scl_dir_o <= 1'b1;
          end
          ST_STOP_C: begin
            state <= ST_STOP_D;  // setup time
          end
          ST_STOP_D: begin
            state     <= ST_IDLE;
            sda_dir_o <= 1'b1;  // SDA rises with SCL high
            cmd_ack_o <= 1'b1;
          end

          ////////////////////////////////////////////////////////////
          // read, SDA left to the slave
          ////////////////////////////////////////////////////////////
          ST_RD_A: begin
            state     <= ST_RD_B;
            scl_dir_o <= 1'b0;
            sda_dir_o <= 1'b1;
          end
          ST_RD_B: begin
            state     <= ST_RD_C;
            scl_dir_o <= 1'b1;
          end
          ST_RD_C: begin
            state <= ST_RD_D;  // second high tick
          end
          ST_RD_D: begin
            state     <= ST_IDLE;
            scl_dir_o <= 1'b0;
            cmd_ack_o <= 1'b1;
          end

          ////////////////////////////////////////////////////////////
          // write, SDA only moves while SCL is low
          ////////////////////////////////////////////////////////////
          ST_WR_A: begin
            state     <= ST_WR_B;
            scl_dir_o <= 1'b0;
            sda_dir_o <= tx_bit_i;
          end
          ST_WR_B: begin
            state     <= ST_WR_C;
            scl_dir_o <= 1'b1;
            sda_dir_o <= tx_bit_i;
          end
          ST_WR_C: begin
            state     <= ST_WR_D;
            sda_dir_o <= tx_bit_i;
          end
          ST_WR_D: begin
            state     <= ST_IDLE;
            scl_dir_o <= 1'b0;
            sda_dir_o <= tx_bit_i;
            cmd_ack_o <= 1'b1;
          end

          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  a_ack_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cmd_ack_o |=> !cmd_ack_o
  );

  // data must not move while the clock is high in a write
  a_wr_sda_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (scl_dir_o && (state == ST_WR_C || state == ST_WR_D)) |-> $stable(sda_dir_o)
  );

endmodule

// ==== i2c_bit_pkg.sv ====
/*
 * I2C bit controller shared definitions
 * widths, glitch filter constants, command and sequencer state encodings
 */
package i2c_bit_pkg;

  ////////////////////////////////////////////////////////////
  // widths and filter constants
  ////////////////////////////////////////////////////////////
  localparam int PRESCALE_W   = 16;  // prescale value and divider counter
  localparam int FILTER_W     = 14;  // filter sample timer
  localparam int FILTER_SHIFT = 2;   // prescale/4, about 16x bus rate
  localparam int FILTER_TAPS  = 3;   // samples in the majority vote
  localparam int SYNC_STAGES  = 2;   // input synchronizer depth

  ////////////////////////////////////////////////////////////
  // bit level commands
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    CMD_NOP   = 4'b0000,
    CMD_START = 4'b0001,  // also repeated start
    CMD_STOP  = 4'b0010,
    CMD_WRITE = 4'b0100,
    CMD_READ  = 4'b1000
  } i2c_cmd_e;

  // sequencer states, one phase per bus tick
  typedef enum logic [4:0] {
    ST_IDLE,
    ST_START_A,
    ST_START_B,
    ST_START_C,
    ST_START_D,
    ST_START_E,
    ST_STOP_A,
    ST_STOP_B,
    ST_STOP_C,
    ST_STOP_D,
    ST_RD_A,
    ST_RD_B,
    ST_RD_C,
    ST_RD_D,
    ST_WR_A,
    ST_WR_B,
    ST_WR_C,
    ST_WR_D
  } bit_state_e;

endpackage

// ==== i2c_bus_monitor.sv ====
/*
 * I2C bus monitor
 * start/stop detection, bus busy flag, received bit capture on SCL rise
 */
`timescale 1ns/100ps

module i2c_bus_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_s_i,   // filtered SCL
  input  logic sda_s_i,   // filtered SDA
  output logic busy_o,    // between start and stop
  output logic rx_bit_o   // SDA at last SCL rise
);

  logic dscl, dsda;          // filtered lines one cycle late
  logic sta_cond, sto_cond;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dscl <= 1'b1;
      dsda <= 1'b1;
    end else begin
      dscl <= scl_s_i;
      dsda <= sda_s_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // start = SDA fall with SCL high, stop = SDA rise with SCL high
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sta_cond <= 1'b0;
      sto_cond <= 1'b0;
    end else begin
      sta_cond <= ~sda_s_i &  dsda & scl_s_i;
      sto_cond <=  sda_s_i & ~dsda & scl_s_i;
    end
  end

  // busy from start until stop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) busy_o <= 1'b0;
    else          busy_o <= (sta_cond | busy_o) & ~sto_cond;
  end

  // data is valid while SCL is high, take it at the rise
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)                rx_bit_o <= 1'b0;
    else if (scl_s_i & ~dscl)    rx_bit_o <= sda_s_i;
  end

  // busy comes up two cycles after SDA fell with SCL high
  a_busy_from_start : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(busy_o) |-> ($past(scl_s_i && !sda_s_i, 2) && $past(sda_s_i, 3))
  );

endmodule

// ==== i2c_clk_div.sv ====
/*
 * I2C bus clock divider
 * one-cycle tick every prescale+1 cycles, frozen while a slave stretches SCL
 */
`timescale 1ns/100ps

module i2c_clk_div import i2c_bit_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  ena_i,       // core enable
  input  logic [PRESCALE_W-1:0] prescale_i,  // bus period in clocks, minus one
  input  logic                  scl_dir_i,   // SCL release level from sequencer
  input  logic                  scl_s_i,     // filtered SCL
  output logic                  clk_en_o     // bus tick
);

  logic [PRESCALE_W-1:0] cnt;
  logic                  dscl_dir;    // scl_dir one cycle late
  logic                  slave_wait;  // slave holds SCL low

  // rising edge of scl_dir marks the master letting go of SCL
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) dscl_dir <= 1'b1;  // line released out of reset
    else          dscl_dir <= scl_dir_i;
  end

  // released but the bus stays low -> slave is stretching
  // held until the filtered line comes up
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slave_wait <= 1'b0;
    end else begin
      slave_wait <= (scl_dir_i & ~dscl_dir & ~scl_s_i) |
                    (slave_wait & ~scl_s_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // prescale counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt      <= '0;
      clk_en_o <= 1'b1;
    end else if (!ena_i) begin  // disabled, tick every cycle
      cnt      <= prescale_i;
      clk_en_o <= 1'b1;
    end else if (slave_wait) begin  // freeze, no tick while stretched
      cnt      <= cnt;
      clk_en_o <= 1'b0;
    end else if (cnt == '0) begin
      cnt      <= prescale_i;  // reload
      clk_en_o <= 1'b1;
    end else begin
      cnt      <= cnt - 1'b1;
      clk_en_o <= 1'b0;
    end
  end

  // the releasing tick lies before the flag, never on top of it
  a_no_tick_in_wait : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (ena_i && $past(ena_i) && slave_wait) |-> !clk_en_o
  );

endmodule

// ==== i2c_line_filter.sv ====
/*
 * I2C line input filter
 * synchronizes SCL and SDA, samples at ~16x bus rate, 2-of-3 majority vote
 */
`timescale 1ns/100ps

module i2c_line_filter import i2c_bit_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  ena_i,
  input  logic [PRESCALE_W-1:0] prescale_i,
  input  logic                  scl_i,    // raw bus SCL
  input  logic                  sda_i,    // raw bus SDA
  output logic                  scl_s_o,  // filtered SCL
  output logic                  sda_s_o   // filtered SDA
);

  logic [SYNC_STAGES-1:0] scl_sync, sda_sync;
  logic [FILTER_W-1:0]    filter_cnt;
  logic [FILTER_TAPS-1:0] scl_hist, sda_hist;  // newest sample in bit 0
  logic                   sample;

  // 2-of-3 vote
  function automatic logic maj3(input logic [FILTER_TAPS-1:0] v);
    return (v[2] & v[1]) | (v[1] & v[0]) | (v[2] & v[0]);
  endfunction

  ////////////////////////////////////////////////////////////
  // synchronizers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_sync <= '1;  // idle bus reads high
      sda_sync <= '1;
    end else begin
      scl_sync <= {scl_sync[SYNC_STAGES-2:0], scl_i};
      sda_sync <= {sda_sync[SYNC_STAGES-2:0], sda_i};
    end
  end

  // sample timer, parked at zero when disabled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)            filter_cnt <= '0;
    else if (!ena_i)         filter_cnt <= '0;
    else if (filter_cnt == '0) filter_cnt <= FILTER_W'(prescale_i >> FILTER_SHIFT);
    else                     filter_cnt <= filter_cnt - 1'b1;
  end

  assign sample = (filter_cnt == '0);

  ////////////////////////////////////////////////////////////
  // sample history and vote
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_hist <= '1;
      sda_hist <= '1;
    end else if (sample) begin
      scl_hist <= {scl_hist[FILTER_TAPS-2:0], scl_sync[SYNC_STAGES-1]};
      sda_hist <= {sda_hist[FILTER_TAPS-2:0], sda_sync[SYNC_STAGES-1]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_s_o <= 1'b1;
      sda_s_o <= 1'b1;
    end else begin
      scl_s_o <= maj3(scl_hist);  // registered vote
      sda_s_o <= maj3(sda_hist);
    end
  end

  // reset history must not produce a spurious low on the bus view
  a_high_after_reset : assert property (
    @(posedge clk_i) $rose(rst_n_i) |=> (scl_s_o && sda_s_o)
  );

endmodule
